// ==== logic/viir_pkg.sv ====
/*
 * Shared sizes, register map and types for the vector IIR block.
 * Vector length is limited to 2**VIIR_MAX_LOG2 positions.
 */
`default_nettype none

package viir_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int VIIR_MAX_LOG2 = 12;
  localparam int VIIR_MAX_LEN  = 1 << VIIR_MAX_LOG2;
  localparam int VIIR_LEN_W    = VIIR_MAX_LOG2 + 1;
  localparam int VIIR_DEPTH    = VIIR_MAX_LEN;

  // AXI4-Lite address width, byte addressed
  localparam int VIIR_ADDR_W = 4;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////
  localparam logic [VIIR_ADDR_W-1:0] VIIR_REG_VECTOR_LEN = 4'h0;
  localparam logic [VIIR_ADDR_W-1:0] VIIR_REG_ALPHA      = 4'h4;
  localparam logic [VIIR_ADDR_W-1:0] VIIR_REG_BETA       = 4'h8;

  // AXI4-Lite response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } viir_resp_e;

  //////////////////////////////////////////////////
  // Data path types
  //////////////////////////////////////////////////

  // Complex sample, I in the upper half
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } viir_sample_t;

  // Live configuration, alpha and beta in Q1.15
  typedef struct packed {
    logic [VIIR_LEN_W-1:0] vector_len;
    logic signed [15:0]    alpha;
    logic signed [15:0]    beta;
  } viir_cfg_t;

  // First pass after restart reads the previous output as zero
  typedef enum logic {
    FIRST_PASS = 1'b0,
    RUNNING    = 1'b1
  } viir_stage_e;

endpackage

`default_nettype wire

// ==== logic/viir_axil_regs.sv ====
/*
 * AXI4-Lite slave for length, alpha and beta. One outstanding write and one read.
 * Unmapped or unaligned addresses answer SLVERR. A VECTOR_LEN write pulses o_restart.
 */
`timescale 1ns/1ps
`default_nettype none

module viir_axil_regs (
  input  logic                             i_ce_clk,
  input  logic                             i_reset,
  // Write address and data
  input  logic                             i_awvalid,
  input  logic [viir_pkg::VIIR_ADDR_W-1:0] i_awaddr,
  output logic                             o_awready,
  input  logic                             i_wvalid,
  input  logic [31:0]                      i_wdata,
  input  logic [3:0]                       i_wstrb,
  output logic                             o_wready,
  // Write response
  output logic                             o_bvalid,
  output logic [1:0]                       o_bresp,
  input  logic                             i_bready,
  // Read address and data
  input  logic                             i_arvalid,
  input  logic [viir_pkg::VIIR_ADDR_W-1:0] i_araddr,
  output logic                             o_arready,
  output logic                             o_rvalid,
  output logic [31:0]                      o_rdata,
  output logic [1:0]                       o_rresp,
  input  logic                             i_rready,
  // Configuration out
  output viir_pkg::viir_cfg_t              o_cfg,
  output logic                             o_restart
);
  import viir_pkg::*;

  viir_cfg_t  cfg_q;
  viir_resp_e bresp_q;
  viir_resp_e rresp_q;
  logic       wr_fire;
  logic       rd_fire;
  logic       wr_hit;
  logic       rd_hit;
  logic [31:0] wr_old;
  logic [31:0] wr_new;
  logic [31:0] rd_val;

  // Byte-lane merge of a write into the current register image
  function automatic logic [31:0] merge_strb(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Zero stores 1, anything above the maximum stores the maximum
  function automatic logic [VIIR_LEN_W-1:0] clamp_len(input logic [31:0] v);
    if (v == 32'd0) begin
      return VIIR_LEN_W'(1);
    end else if (v > VIIR_MAX_LEN) begin
      return VIIR_LEN_W'(VIIR_MAX_LEN);
    end
    return v[VIIR_LEN_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  // AW and W are taken together, only with no response pending
  assign wr_fire   = i_awvalid & i_wvalid & ~o_bvalid;
  assign o_awready = wr_fire;
  assign o_wready  = wr_fire;
  assign o_restart = wr_fire & (i_awaddr == VIIR_REG_VECTOR_LEN);

  always_comb begin
    wr_hit = 1'b1;
    case (i_awaddr)
      VIIR_REG_VECTOR_LEN: wr_old = 32'(cfg_q.vector_len);
      VIIR_REG_ALPHA:      wr_old = {16'h0000, cfg_q.alpha};
      VIIR_REG_BETA:       wr_old = {16'h0000, cfg_q.beta};
      default: begin
        wr_old = 32'd0;
        wr_hit = 1'b0;
      end
    endcase
  end

  assign wr_new = merge_strb(wr_old, i_wdata, i_wstrb);

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      cfg_q.vector_len <= VIIR_LEN_W'(1);
      cfg_q.alpha      <= 16'sh0000;
      cfg_q.beta       <= 16'sh7fff;
      o_bvalid         <= 1'b0;
      bresp_q          <= OKAY;
    end else begin
      if (wr_fire) begin
        o_bvalid <= 1'b1;
        bresp_q  <= wr_hit ? OKAY : SLVERR;
        case (i_awaddr)
          VIIR_REG_VECTOR_LEN: cfg_q.vector_len <= clamp_len(wr_new);
          VIIR_REG_ALPHA:      cfg_q.alpha      <= wr_new[15:0];
          VIIR_REG_BETA:       cfg_q.beta       <= wr_new[15:0];
          default: ;
        endcase
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////
  assign o_arready = ~o_rvalid;
  assign rd_fire   = i_arvalid & o_arready;

  always_comb begin
    rd_hit = 1'b1;
    case (i_araddr)
      VIIR_REG_VECTOR_LEN: rd_val = 32'(cfg_q.vector_len);
      VIIR_REG_ALPHA:      rd_val = {16'h0000, cfg_q.alpha};
      VIIR_REG_BETA:       rd_val = {16'h0000, cfg_q.beta};
      default: begin
        rd_val = 32'd0;
        rd_hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      o_rvalid <= 1'b0;
      rresp_q  <= OKAY;
    end else if (rd_fire) begin
      o_rvalid <= 1'b1;
      rresp_q  <= rd_hit ? OKAY : SLVERR;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  // Read data captured with the address
  always_ff @(posedge i_ce_clk) begin
    if (rd_fire) begin
      o_rdata <= rd_val;
    end
  end

  assign o_bresp = bresp_q;
  assign o_rresp = rresp_q;
  assign o_cfg   = cfg_q;

endmodule

`default_nettype wire

// ==== logic/viir_delay_ram.sv ====
/*
 * Simple dual-port store of the previous output vector, registered read.
 * Contents are not initialized and read-during-write returns the old word.
 */
`timescale 1ns/1ps
`default_nettype none

module viir_delay_ram (
  input  logic                               i_ce_clk,
  input  logic                               i_we,
  input  logic [viir_pkg::VIIR_MAX_LOG2-1:0] i_waddr,
  input  viir_pkg::viir_sample_t             i_wdata,
  input  logic [viir_pkg::VIIR_MAX_LOG2-1:0] i_raddr,
  output viir_pkg::viir_sample_t             o_rdata
);
  import viir_pkg::*;

  // One complex sample per vector position
  viir_sample_t mem [VIIR_DEPTH];

  always_ff @(posedge i_ce_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Data valid one cycle after the address
  always_ff @(posedge i_ce_clk) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

`default_nettype wire

// ==== logic/vector_iir.sv ====
/*
 * Two-stage vector IIR, y[k] = alpha*y_prev[k] + beta*x[k], shifted by 15 and saturated.
 * Both stages stall together under back-pressure. Config changes take effect at once.
 */
`timescale 1ns/1ps
`default_nettype none

module vector_iir (
  input  logic                               i_ce_clk,
  input  logic                               i_reset,
  input  viir_pkg::viir_cfg_t                i_cfg,
  input  logic                               i_restart,
  // Input stream
  input  viir_pkg::viir_sample_t             i_tdata,
  input  logic                               i_tlast,
  input  logic                               i_tvalid,
  output logic                               o_tready,
  // Output stream
  output viir_pkg::viir_sample_t             o_tdata,
  output logic                               o_tlast,
  output logic                               o_tvalid,
  input  logic                               i_otready,
  // Delay memory
  output logic                               o_mem_we,
  output logic [viir_pkg::VIIR_MAX_LOG2-1:0] o_mem_waddr,
  output viir_pkg::viir_sample_t             o_mem_wdata,
  output logic [viir_pkg::VIIR_MAX_LOG2-1:0] o_mem_raddr,
  input  viir_pkg::viir_sample_t             i_mem_rdata
);
  import viir_pkg::*;

  logic                     adv;
  logic                     in_fire;
  logic                     wrap;
  logic [VIIR_MAX_LOG2-1:0] pos_cnt;
  viir_stage_e              stage;

  // Stage 1
  logic                     s1_valid;
  viir_sample_t             s1_data;
  logic [VIIR_MAX_LOG2-1:0] s1_pos;
  logic                     s1_last;
  viir_stage_e              s1_stage;

  // Stage 2
  logic                     s2_valid;
  viir_sample_t             s2_data;
  logic [VIIR_MAX_LOG2-1:0] s2_pos;
  logic                     s2_last;

  logic                     fwd;
  viir_sample_t             prev;
  viir_sample_t             result;

  // Q1.15 multiply-add, floor shift and saturation to 16 bits
  function automatic logic signed [15:0] mac_sat(input logic signed [15:0] a,
                                                 input logic signed [15:0] y,
                                                 input logic signed [15:0] b,
                                                 input logic signed [15:0] x);
    logic signed [31:0] p_a;
    logic signed [31:0] p_b;
    logic signed [32:0] sum;
    logic        [17:0] sh;
    p_a = a * y;
    p_b = b * x;
    sum = {p_a[31], p_a} + {p_b[31], p_b};
    sh  = sum[32:15];
    if (sh[17:15] == {3{sh[15]}}) begin
      return sh[15:0];
    end
    return sh[17] ? 16'sh8000 : 16'sh7fff;
  endfunction

  //////////////////////////////////////////////////
  // Flow control and position
  //////////////////////////////////////////////////

  // One enable for the whole pipe
  assign adv      = ~s2_valid | i_otready;
  assign o_tready = adv;
  assign in_fire  = i_tvalid & adv;
  assign wrap     = ({1'b0, pos_cnt} + 1'b1) == i_cfg.vector_len;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset || i_restart) begin
      pos_cnt <= '0;
      stage   <= FIRST_PASS;
    end else if (in_fire) begin
      if (wrap) begin
        pos_cnt <= '0;
        stage   <= RUNNING;
      end else begin
        pos_cnt <= pos_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage 1, sample capture and memory read
  //////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
    end else if (adv) begin
      s1_valid <= i_tvalid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (adv) begin
      s1_data  <= i_tdata;
      s1_pos   <= pos_cnt;
      s1_last  <= i_tlast;
      s1_stage <= stage;
    end
  end

  // Re-read the held position while stalled
  assign o_mem_raddr = adv ? pos_cnt : s1_pos;

  //////////////////////////////////////////////////
  // Stage 2, arithmetic and write-back
  //////////////////////////////////////////////////

  // Memory misses a write from the same edge as the read
  assign fwd = s2_valid & (s2_pos == s1_pos);

  always_comb begin
    if (s1_stage == FIRST_PASS) begin
      prev = '0;
    end else if (fwd) begin
      prev = s2_data;
    end else begin
      prev = i_mem_rdata;
    end
  end

  always_comb begin
    result.i = mac_sat(i_cfg.alpha, prev.i, i_cfg.beta, s1_data.i);
    result.q = mac_sat(i_cfg.alpha, prev.q, i_cfg.beta, s1_data.q);
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      s2_valid <= 1'b0;
    end else if (adv) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (adv) begin
      s2_data <= result;
      s2_pos  <= s1_pos;
      s2_last <= s1_last;
    end
  end

  // Result lands in memory on the same edge as stage 2
  assign o_mem_we    = adv & s1_valid;
  assign o_mem_waddr = s1_pos;
  assign o_mem_wdata = result;

  assign o_tdata  = s2_data;
  assign o_tlast  = s2_last;
  assign o_tvalid = s2_valid;

endmodule

`default_nettype wire

// ==== logic/noc_block_vector_iir.sv ====
/*
 * Vector IIR block on one clock, AXI4-Lite configuration and 32-bit I/Q streams.
 */
`timescale 1ns/1ps
`default_nettype none

module noc_block_vector_iir (
  input  logic                             i_ce_clk,
  input  logic                             i_reset,
  // AXI4-Lite
  input  logic                             i_awvalid,
  input  logic [viir_pkg::VIIR_ADDR_W-1:0] i_awaddr,
  output logic                             o_awready,
  input  logic                             i_wvalid,
  input  logic [31:0]                      i_wdata,
  input  logic [3:0]                       i_wstrb,
  output logic                             o_wready,
  output logic                             o_bvalid,
  output logic [1:0]                       o_bresp,
  input  logic                             i_bready,
  input  logic                             i_arvalid,
  input  logic [viir_pkg::VIIR_ADDR_W-1:0] i_araddr,
  output logic                             o_arready,
  output logic                             o_rvalid,
  output logic [31:0]                      o_rdata,
  output logic [1:0]                       o_rresp,
  input  logic                             i_rready,
  // Sample streams
  input  viir_pkg::viir_sample_t           i_tdata,
  input  logic                             i_tlast,
  input  logic                             i_tvalid,
  output logic                             o_tready,
  output viir_pkg::viir_sample_t           o_tdata,
  output logic                             o_tlast,
  output logic                             o_tvalid,
  input  logic                             i_otready
);
  import viir_pkg::*;

  viir_cfg_t                cfg;
  logic                     restart;
  logic                     mem_we;
  logic [VIIR_MAX_LOG2-1:0] mem_waddr;
  logic [VIIR_MAX_LOG2-1:0] mem_raddr;
  viir_sample_t             mem_wdata;
  viir_sample_t             mem_rdata;

  //////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////
  viir_axil_regs u_regs (
    .i_ce_clk (i_ce_clk),  .i_reset  (i_reset),
    .i_awvalid(i_awvalid), .i_awaddr (i_awaddr), .o_awready(o_awready),
    .i_wvalid (i_wvalid),  .i_wdata  (i_wdata),  .i_wstrb  (i_wstrb),
    .o_wready (o_wready),
    .o_bvalid (o_bvalid),  .o_bresp  (o_bresp),  .i_bready (i_bready),
    .i_arvalid(i_arvalid), .i_araddr (i_araddr), .o_arready(o_arready),
    .o_rvalid (o_rvalid),  .o_rdata  (o_rdata),  .o_rresp  (o_rresp),
    .i_rready (i_rready),
    .o_cfg    (cfg),       .o_restart(restart)
  );

  //////////////////////////////////////////////////
  // Filter core and delay memory
  //////////////////////////////////////////////////
  vector_iir u_core (
    .i_ce_clk   (i_ce_clk),  .i_reset    (i_reset),
    .i_cfg      (cfg),       .i_restart  (restart),
    .i_tdata    (i_tdata),   .i_tlast    (i_tlast),
    .i_tvalid   (i_tvalid),  .o_tready   (o_tready),
    .o_tdata    (o_tdata),   .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),  .i_otready  (i_otready),
    .o_mem_we   (mem_we),    .o_mem_waddr(mem_waddr),
    .o_mem_wdata(mem_wdata), .o_mem_raddr(mem_raddr),
    .i_mem_rdata(mem_rdata)
  );

  viir_delay_ram u_ram (
    .i_ce_clk(i_ce_clk),
    .i_we    (mem_we),
    .i_waddr (mem_waddr),
    .i_wdata (mem_wdata),
    .i_raddr (mem_raddr),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== bench/vector_iir_sva.sv ====
/*
 * Protocol and reset checks bound to every vector IIR top level.
 * Assumes all inputs change away from the rising clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module vector_iir_sva (
  input logic                   i_ce_clk,
  input logic                   i_reset,
  input logic                   i_tvalid,
  input logic                   o_tready,
  input viir_pkg::viir_sample_t o_tdata,
  input logic                   o_tlast,
  input logic                   o_tvalid,
  input logic                   i_otready,
  input logic                   o_bvalid,
  input logic                   i_bready,
  input logic                   o_rvalid,
  input logic                   i_rready
);

  // All handshake outputs idle right after reset
  a_reset_idle: assert property (@(posedge i_ce_clk)
    i_reset |=> (!o_tvalid && !o_bvalid && !o_rvalid))
    else $error("valid outputs high in the cycle after reset");

  //////////////////////////////////////////////////
  // Hold rules
  //////////////////////////////////////////////////
  a_out_hold: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_tvalid && !i_otready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)))
    else $error("output sample changed while stalled");

  a_b_hold: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_bvalid && !i_bready) |=> o_bvalid)
    else $error("write response dropped before bready");

  a_r_hold: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_rvalid && !i_rready) |=> o_rvalid)
    else $error("read response dropped before rready");

  // Two-cycle latency with the output side open
  a_latency: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    ($past(i_tvalid && o_tready && i_otready) && i_otready) |=> o_tvalid)
    else $error("accepted sample not presented two cycles later");

endmodule

bind noc_block_vector_iir vector_iir_sva u_sva (
  .i_ce_clk (i_ce_clk),
  .i_reset  (i_reset),
  .i_tvalid (i_tvalid),
  .o_tready (o_tready),
  .o_tdata  (o_tdata),
  .o_tlast  (o_tlast),
  .o_tvalid (o_tvalid),
  .i_otready(i_otready),
  .o_bvalid (o_bvalid),
  .i_bready (i_bready),
  .o_rvalid (o_rvalid),
  .i_rready (i_rready)
);

`default_nettype wire

// ==== bench/tb_vector_iir.sv ====
/*
 * Self-checking testbench with a bit-true reference model of the filter.
 * Stimulus comes from a fixed-seed LFSR. Config only changes while the pipe is empty.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_iir;
  import viir_pkg::*;

  localparam int TIMEOUT = 2000;

  logic                   i_ce_clk = 1'b0;
  logic                   i_reset;
  logic                   i_awvalid;
  logic [VIIR_ADDR_W-1:0] i_awaddr;
  logic                   o_awready;
  logic                   i_wvalid;
  logic [31:0]            i_wdata;
  logic [3:0]             i_wstrb;
  logic                   o_wready;
  logic                   o_bvalid;
  logic [1:0]             o_bresp;
  logic                   i_bready;
  logic                   i_arvalid;
  logic [VIIR_ADDR_W-1:0] i_araddr;
  logic                   o_arready;
  logic                   o_rvalid;
  logic [31:0]            o_rdata;
  logic [1:0]             o_rresp;
  logic                   i_rready;
  viir_sample_t           i_tdata;
  logic                   i_tlast;
  logic                   i_tvalid;
  logic                   o_tready;
  viir_sample_t           o_tdata;
  logic                   o_tlast;
  logic                   o_tvalid;
  logic                   i_otready;

  // Reference model state
  int                 m_len;
  int                 m_pos;
  bit                 m_first;
  logic signed [15:0] m_alpha;
  logic signed [15:0] m_beta;
  logic signed [15:0] m_prev_i [VIIR_MAX_LEN];
  logic signed [15:0] m_prev_q [VIIR_MAX_LEN];
  viir_sample_t       exp_data_q [$];
  logic               exp_last_q [$];
  int                 in_count;
  int                 out_count;

  logic [31:0] lfsr;
  bit          bp_on;
  bit          gaps_on;
  bit          ext_mode;

  noc_block_vector_iir u_dut (.*);

  always #2 i_ce_clk = ~i_ce_clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    abort_run($sformatf("MISMATCH %s expected 0x%0h got 0x%0h", name, exp_v, got_v));
  endtask

  // Taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [15:0] pick_value();
    if (ext_mode || take_bits(3) == 32'd0) begin
      case (take_bits(2))
        32'd0:   return 16'h7fff;
        32'd1:   return 16'h8000;
        32'd2:   return 16'h8001;
        default: return 16'h0000;
      endcase
    end
    return 16'(take_bits(16));
  endfunction

  // alpha*y + beta*x, floor shift by 15, clamp to 16 bits
  function automatic logic signed [15:0] ref_filter(input logic signed [15:0] a,
                                                    input logic signed [15:0] y,
                                                    input logic signed [15:0] b,
                                                    input logic signed [15:0] x);
    longint acc;
    acc = (longint'(a) * longint'(y)) + (longint'(b) * longint'(x));
    acc = acc >>> 15;
    if (acc > 32767) begin
      return 16'sh7fff;
    end else if (acc < -32768) begin
      return 16'sh8000;
    end
    return acc[15:0];
  endfunction

  task automatic drive_ready();
    i_otready = bp_on ? (take_bits(2) != 32'd0) : 1'b1;
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite access
  //////////////////////////////////////////////////
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int cnt;
    @(negedge i_ce_clk);
    i_awvalid = 1'b1;
    i_awaddr  = addr;
    i_wvalid  = 1'b1;
    i_wdata   = data;
    i_wstrb   = 4'hf;
    cnt = 0;
    @(posedge i_ce_clk);
    while (!o_awready) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("write address never accepted");
      @(posedge i_ce_clk);
    end
    assert (o_wready) else report_mismatch("o_wready", 32'd1, {31'd0, o_wready});
    @(negedge i_ce_clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    // Response sits unclaimed for one cycle
    @(negedge i_ce_clk);
    i_bready  = 1'b1;
    cnt = 0;
    @(posedge i_ce_clk);
    while (!o_bvalid) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("write response never arrived");
      @(posedge i_ce_clk);
    end
    resp = o_bresp;
    @(negedge i_ce_clk);
    i_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int cnt;
    @(negedge i_ce_clk);
    i_arvalid = 1'b1;
    i_araddr  = addr;
    cnt = 0;
    @(posedge i_ce_clk);
    while (!o_arready) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("read address never accepted");
      @(posedge i_ce_clk);
    end
    @(negedge i_ce_clk);
    i_arvalid = 1'b0;
    // Read data waits one cycle before rready
    @(negedge i_ce_clk);
    i_rready  = 1'b1;
    cnt = 0;
    @(posedge i_ce_clk);
    while (!o_rvalid) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("read response never arrived");
      @(posedge i_ce_clk);
    end
    data = o_rdata;
    resp = o_rresp;
    @(negedge i_ce_clk);
    i_rready = 1'b0;
  endtask

  // Mapped write, model follows the stored value
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    assert (resp == OKAY) else report_mismatch("o_bresp", 32'(OKAY), 32'(resp));
    if (addr == VIIR_REG_VECTOR_LEN) begin
      if (data == 32'd0) begin
        m_len = 1;
      end else if (data > 32'd4096) begin
        m_len = 4096;
      end else begin
        m_len = int'(data);
      end
      m_pos   = 0;
      m_first = 1'b1;
    end else if (addr == VIIR_REG_ALPHA) begin
      m_alpha = data[15:0];
    end else if (addr == VIIR_REG_BETA) begin
      m_beta = data[15:0];
    end
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp_v);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    assert (resp == OKAY) else report_mismatch("o_rresp", 32'(OKAY), 32'(resp));
    assert (data == exp_v) else report_mismatch("o_rdata", exp_v, data);
  endtask

  task automatic set_cfg(input int len, input logic [31:0] a, input logic [31:0] b);
    write_reg(VIIR_REG_ALPHA, a);
    write_reg(VIIR_REG_BETA, b);
    write_reg(VIIR_REG_VECTOR_LEN, 32'(len));
  endtask

  //////////////////////////////////////////////////
  // Stream driving
  //////////////////////////////////////////////////
  task automatic send_samples(input int n);
    int gap;
    int stall;
    for (int k = 0; k < n; k++) begin
      gap = gaps_on ? int'(take_bits(2)) : 0;
      for (int g = 0; g < gap; g++) begin
        @(negedge i_ce_clk);
        i_tvalid = 1'b0;
        drive_ready();
      end
      @(negedge i_ce_clk);
      i_tvalid  = 1'b1;
      i_tdata.i = pick_value();
      i_tdata.q = pick_value();
      i_tlast   = take_bits(1) != 32'd0;
      drive_ready();
      stall = 0;
      @(posedge i_ce_clk);
      // Hold the sample until the core takes it
      while (!o_tready) begin
        stall++;
        if (stall > TIMEOUT) abort_run("input stream stalled too long");
        @(negedge i_ce_clk);
        drive_ready();
        @(posedge i_ce_clk);
      end
    end
    @(negedge i_ce_clk);
    i_tvalid = 1'b0;
  endtask

  task automatic drain_outputs();
    int cnt;
    cnt = 0;
    while (out_count != in_count) begin
      cnt++;
      if (cnt > TIMEOUT) abort_run("outputs did not drain");
      @(negedge i_ce_clk);
      drive_ready();
    end
    @(negedge i_ce_clk);
    i_otready = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Model and output check
  //////////////////////////////////////////////////
  always @(posedge i_ce_clk) begin
    viir_sample_t exp_s;
    viir_sample_t prev_s;
    logic         exp_l;
    if (!i_reset) begin
      if (o_tvalid && i_otready) begin
        assert (exp_data_q.size() > 0) else abort_run("output with no input outstanding");
        exp_s = exp_data_q.pop_front();
        exp_l = exp_last_q.pop_front();
        assert (o_tdata.i == exp_s.i)
          else report_mismatch("o_tdata.i", {16'h0, exp_s.i}, {16'h0, o_tdata.i});
        assert (o_tdata.q == exp_s.q)
          else report_mismatch("o_tdata.q", {16'h0, exp_s.q}, {16'h0, o_tdata.q});
        assert (o_tlast == exp_l)
          else report_mismatch("o_tlast", {31'd0, exp_l}, {31'd0, o_tlast});
        out_count++;
      end
      if (i_tvalid && o_tready) begin
        // Previous output reads as zero until the first wrap
        prev_s.i = m_first ? 16'sd0 : m_prev_i[m_pos];
        prev_s.q = m_first ? 16'sd0 : m_prev_q[m_pos];
        exp_s.i  = ref_filter(m_alpha, prev_s.i, m_beta, i_tdata.i);
        exp_s.q  = ref_filter(m_alpha, prev_s.q, m_beta, i_tdata.q);
        m_prev_i[m_pos] = exp_s.i;
        m_prev_q[m_pos] = exp_s.q;
        exp_data_q.push_back(exp_s);
        exp_last_q.push_back(i_tlast);
        in_count++;
        if (m_pos + 1 >= m_len) begin
          m_pos   = 0;
          m_first = 1'b0;
        end else begin
          m_pos++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    logic [1:0]  resp;
    i_reset   = 1'b1;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    i_tdata   = '0;
    i_tlast   = 1'b0;
    i_tvalid  = 1'b0;
    i_otready = 1'b1;
    lfsr      = 32'hdc0b81cb;
    m_len     = 1;
    m_pos     = 0;
    m_first   = 1'b1;
    m_alpha   = 16'sh0000;
    m_beta    = 16'sh7fff;
    in_count  = 0;
    out_count = 0;
    bp_on     = 1'b0;
    gaps_on   = 1'b0;
    ext_mode  = 1'b0;
    repeat (4) @(posedge i_ce_clk);
    @(negedge i_ce_clk);
    i_reset = 1'b0;

    // Register map, clamping and unmapped address
    check_reg(VIIR_REG_VECTOR_LEN, 32'd1);
    check_reg(VIIR_REG_ALPHA, 32'h0);
    check_reg(VIIR_REG_BETA, 32'h7fff);
    write_reg(VIIR_REG_VECTOR_LEN, 32'd0);
    check_reg(VIIR_REG_VECTOR_LEN, 32'd1);
    write_reg(VIIR_REG_VECTOR_LEN, 32'd5000);
    check_reg(VIIR_REG_VECTOR_LEN, 32'd4096);
    write_reg(VIIR_REG_ALPHA, 32'h1234_8765);
    check_reg(VIIR_REG_ALPHA, 32'h0000_8765);
    write_reg(VIIR_REG_BETA, 32'h0000_4321);
    check_reg(VIIR_REG_BETA, 32'h0000_4321);
    axil_write(4'hc, 32'h55, resp);
    assert (resp == SLVERR) else report_mismatch("o_bresp", 32'(SLVERR), 32'(resp));
    axil_read(4'hc, rdata, resp);
    assert (resp == SLVERR) else report_mismatch("o_rresp", 32'(SLVERR), 32'(resp));

    // Pass-through
    set_cfg(4, 32'h0, 32'h7fff);
    send_samples(16);
    drain_outputs();

    // Recursion, then both saturation directions
    set_cfg(8, take_bits(16), take_bits(16));
    send_samples(40);
    drain_outputs();
    ext_mode = 1'b1;
    set_cfg(8, 32'h8000, 32'h8000);
    send_samples(24);
    drain_outputs();
    set_cfg(8, 32'h7fff, 32'h7fff);
    send_samples(24);
    drain_outputs();
    ext_mode = 1'b0;

    // Forwarding with short vectors
    set_cfg(1, take_bits(16), take_bits(16));
    send_samples(20);
    drain_outputs();
    set_cfg(2, take_bits(16), take_bits(16));
    send_samples(20);
    drain_outputs();

    // Back-pressure and input gaps
    bp_on   = 1'b1;
    gaps_on = 1'b1;
    set_cfg(5, take_bits(16), take_bits(16));
    send_samples(60);
    drain_outputs();
    bp_on   = 1'b0;
    gaps_on = 1'b0;

    // Restart in the middle of a vector
    set_cfg(6, take_bits(16), take_bits(16));
    send_samples(9);
    drain_outputs();
    write_reg(VIIR_REG_VECTOR_LEN, 32'd6);
    send_samples(12);
    drain_outputs();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
logic/viir_pkg.sv
logic/viir_axil_regs.sv
logic/viir_delay_ram.sv
logic/vector_iir.sv
logic/noc_block_vector_iir.sv
bench/vector_iir_sva.sv
bench/tb_vector_iir.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector IIR testbench with Verilator.
# The exit status is the simulator's, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_vector_iir -o tb_vector_iir
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/tb_vector_iir
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
